/* include/fp_misc_config.svh */
// ====================
// Widths, operation codes and constants shared by the FP misc unit.
// Included by the package and by every module that decodes ops.
// ====================
`ifndef FP_MISC_CONFIG_SVH
`define FP_MISC_CONFIG_SVH

`define FLEN_D 64 // Register width.
`define FLEN_S 32 // Single width.

`define FMT_S 2'd0
`define FMT_D 2'd1

`define FT_MIN     5'd3
`define FT_MAX     5'd4
`define FT_SGNJ    5'd17
`define FT_SGNJN   5'd18
`define FT_SGNJX   5'd19
`define FT_EQ      5'd20
`define FT_LT      5'd21
`define FT_LE      5'd22
`define FT_CLASS   5'd23
`define FT_MV_TO_F 5'd24 // Integer word into the FP register.
`define FT_MV_TO_X 5'd25 // FP register out to an integer word.

`define QNAN_S 32'h7FC0_0000
`define QNAN_D 64'h7FF8_0000_0000_0000

`define FLAG_NV 4 // Invalid-operation bit.

`endif

/* logic/fp_misc_pkg.sv */
`default_nettype none
// ====================
// Float, register, flag and class types for the FP misc unit.
// ====================
`include "fp_misc_config.svh"

package fp_misc_pkg;

	// ====================
	// Float formats
	typedef struct packed {
		logic sign;
		logic [7:0] exp;
		logic [22:0] frac;
	} fp32_t;

	typedef struct packed {
		logic sign;
		logic [10:0] exp;
		logic [51:0] frac;
	} fp64_t;

	// ====================
	// Register and control
	typedef logic [`FLEN_D-1:0] freg_t; // Single values live NaN-boxed.
	typedef logic [4:0] ftype_t;
	typedef logic [1:0] fmt_t;

	// NV, DZ, OF, UF, NX from bit 4 down to bit 0.
	typedef logic [4:0] fflags_t;

	// Bit 0 is negative infinity, bit 9 is quiet NaN.
	typedef logic [9:0] fclass_t;

endpackage

`default_nettype wire

/* logic/fp_operand_stage.sv */
`default_nettype none
// ====================
// Input register of the FP misc pipeline. Captures one op per in_valid
// strobe and flags which operands are properly NaN-boxed singles.
// ====================
`include "fp_misc_config.svh"

module fp_operand_stage (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire fp_misc_pkg::fmt_t fmt,
	input wire fp_misc_pkg::ftype_t ftype,
	input wire fp_misc_pkg::freg_t frs1,
	input wire fp_misc_pkg::freg_t frs2,
	output logic op_valid,
	output fp_misc_pkg::fmt_t op_fmt,
	output fp_misc_pkg::ftype_t op_ftype,
	output fp_misc_pkg::freg_t op_a,
	output fp_misc_pkg::freg_t op_b,
	output logic op_a_boxed,
	output logic op_b_boxed
);

	// Upper half all zeros or all ones counts as a boxed single.
	function automatic logic is_boxed(input fp_misc_pkg::freg_t x);
		logic [`FLEN_D-`FLEN_S-1:0] upper;
		upper = x[`FLEN_D-1:`FLEN_S];
		return (&upper) | ~(|upper);
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= in_valid; // One cycle behind the strobe.
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_fmt <= fmt;
			op_ftype <= ftype;
			op_a <= frs1;
			op_b <= frs2;
			op_a_boxed <= is_boxed(frs1);
			op_b_boxed <= is_boxed(frs2);
		end
	end

	a_op_known: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> !$isunknown({fmt, ftype}))
		else $error("fp_operand_stage: unknown fmt or ftype with in_valid");

endmodule

`default_nettype wire

/* logic/fp_compare_unit.sv */
`default_nettype none
// ====================
// Compare, min/max, sign injection and fclass for one IEEE format.
// Instantiated once per format with the matching float type.
// ====================
`include "fp_misc_config.svh"

module fp_compare_unit #(
	parameter type float_t = fp_misc_pkg::fp32_t
) (
	input wire float_t a,
	input wire float_t b,
	output logic lt,
	output logic eq,
	output logic unordered,
	output logic cmp_invalid,
	output float_t min_res,
	output float_t max_res,
	output logic minmax_invalid,
	output float_t sgnj_res,
	output float_t sgnjn_res,
	output float_t sgnjx_res,
	output fp_misc_pkg::fclass_t class_mask
);

	localparam int W = $bits(float_t);
	localparam logic [W-1:0] QNAN_BITS = (W == `FLEN_S) ? W'(`QNAN_S) : W'(`QNAN_D);
	localparam float_t QNAN = float_t'(QNAN_BITS); // Canonical NaN.

	localparam int CLS_NZERO = 3;
	localparam int CLS_PZERO = 4;
	localparam int CLS_SNAN = 8;
	localparam int CLS_QNAN = 9;

	fp_misc_pkg::fclass_t a_cls, b_cls;
	logic a_nan, b_nan, both_zero;
	logic [W-2:0] a_mag, b_mag;
	logic raw_lt, raw_eq, a_first;

	// ====================
	// Field decode
	function automatic fp_misc_pkg::fclass_t classify(input float_t x);
		logic exp_max, exp_zero, frac_zero, quiet;
		fp_misc_pkg::fclass_t m;
		exp_max = &x.exp;
		exp_zero = ~|x.exp;
		frac_zero = ~|x.frac;
		quiet = |(x.frac & QNAN.frac); // Top fraction bit.
		m = '0;
		m[0] = x.sign & exp_max & frac_zero;
		m[1] = x.sign & ~exp_max & ~exp_zero;
		m[2] = x.sign & exp_zero & ~frac_zero;
		m[3] = x.sign & exp_zero & frac_zero;
		m[4] = ~x.sign & exp_zero & frac_zero;
		m[5] = ~x.sign & exp_zero & ~frac_zero;
		m[6] = ~x.sign & ~exp_max & ~exp_zero;
		m[7] = ~x.sign & exp_max & frac_zero;
		m[8] = exp_max & ~frac_zero & ~quiet;
		m[9] = exp_max & quiet;
		return m;
	endfunction

	assign a_cls = classify(a);
	assign b_cls = classify(b);
	assign a_nan = a_cls[CLS_SNAN] | a_cls[CLS_QNAN];
	assign b_nan = b_cls[CLS_SNAN] | b_cls[CLS_QNAN];
	assign both_zero = (a_cls[CLS_NZERO] | a_cls[CLS_PZERO]) &
		(b_cls[CLS_NZERO] | b_cls[CLS_PZERO]);
	assign class_mask = a_cls;

	// ====================
	// Ordered compare
	assign a_mag = a[W-2:0];
	assign b_mag = b[W-2:0];

	always_comb begin
		if (both_zero) begin
			raw_lt = 1'b0; // +0 equals -0.
		end else if (a.sign != b.sign) begin
			raw_lt = a.sign;
		end else if (a.sign) begin
			raw_lt = a_mag > b_mag; // Both negative, larger magnitude is smaller.
		end else begin
			raw_lt = a_mag < b_mag;
		end
	end

	assign raw_eq = (a == b) | both_zero;
	assign unordered = a_nan | b_nan;
	assign lt = raw_lt & ~unordered;
	assign eq = raw_eq & ~unordered;
	assign cmp_invalid = unordered; // Signaling compares trap on any NaN.
	assign minmax_invalid = a_cls[CLS_SNAN] | b_cls[CLS_SNAN];

	// ====================
	// Min and max
	assign a_first = both_zero ? (a.sign & ~b.sign) : raw_lt; // -0 below +0.

	always_comb begin
		if (a_nan && b_nan) begin
			min_res = QNAN;
			max_res = QNAN;
		end else if (a_nan) begin
			min_res = b;
			max_res = b;
		end else if (b_nan) begin
			min_res = a;
			max_res = a;
		end else begin
			min_res = a_first ? a : b;
			max_res = a_first ? b : a;
		end
	end

	// Sign injection keeps the magnitude of a.
	always_comb begin
		sgnj_res = a;
		sgnjn_res = a;
		sgnjx_res = a;
		sgnj_res.sign = b.sign;
		sgnjn_res.sign = ~b.sign;
		sgnjx_res.sign = a.sign ^ b.sign;
	end

	always_comb begin
		assert (!(lt && eq)) else $error("fp_compare_unit: lt and eq both set");
	end

endmodule

`default_nettype wire

/* logic/fp_result_select.sv */
`default_nettype none
// ====================
// Output register of the FP misc pipeline. Picks the result for fmt and
// ftype, applies single boxing rules and registers result and flags.
// ====================
`include "fp_misc_config.svh"

module fp_result_select (
	input wire clk,
	input wire reset,
	input wire op_valid,
	input wire fp_misc_pkg::fmt_t op_fmt,
	input wire fp_misc_pkg::ftype_t op_ftype,
	input wire fp_misc_pkg::freg_t op_a,
	input wire fp_misc_pkg::freg_t op_b,
	input wire op_a_boxed,
	input wire op_b_boxed,
	input wire s_lt, s_eq, s_unordered, s_cmp_invalid, s_minmax_invalid,
	input wire fp_misc_pkg::fp32_t s_min_res, s_max_res,
	input wire fp_misc_pkg::fp32_t s_sgnj_res, s_sgnjn_res, s_sgnjx_res,
	input wire fp_misc_pkg::fclass_t s_class_mask,
	input wire d_lt, d_eq, d_unordered, d_cmp_invalid, d_minmax_invalid,
	input wire fp_misc_pkg::fp64_t d_min_res, d_max_res,
	input wire fp_misc_pkg::fp64_t d_sgnj_res, d_sgnjn_res, d_sgnjx_res,
	input wire fp_misc_pkg::fclass_t d_class_mask,
	output logic out_valid,
	output fp_misc_pkg::freg_t farith_res,
	output fp_misc_pkg::fflags_t exception_flags,
	output logic fflags_valid
);

	localparam logic [`FLEN_S-1:0] BOX = '1;

	fp_misc_pkg::freg_t nxt_res;
	fp_misc_pkg::fflags_t nxt_flags;
	logic is_s, is_d, two_src, one_src, unboxed, nxt_fv, nv;

	assign is_s = op_fmt == `FMT_S;
	assign is_d = op_fmt == `FMT_D;
	assign two_src = op_ftype inside {`FT_MIN, `FT_MAX, `FT_SGNJ, `FT_SGNJN, `FT_SGNJX};
	assign one_src = op_ftype inside {`FT_CLASS, `FT_MV_TO_F};
	assign unboxed = is_s & ((two_src & ~(op_a_boxed & op_b_boxed)) | (one_src & ~op_a_boxed));

	// Compares and min/max raise flags, feq only on signaling NaN.
	assign nxt_fv = unboxed | ((is_s | is_d) &
		(op_ftype inside {`FT_MIN, `FT_MAX, `FT_EQ, `FT_LT, `FT_LE}));
	assign nv = (op_ftype inside {`FT_LT, `FT_LE}) ?
		(is_s ? s_cmp_invalid : d_cmp_invalid) :
		(is_s ? s_minmax_invalid : d_minmax_invalid);

	always_comb begin
		nxt_flags = '0;
		nxt_flags[`FLAG_NV] = unboxed | (nxt_fv & nv);
		nxt_res = '0;
		if (unboxed) begin
			nxt_res = {{`FLEN_S{1'b0}}, `QNAN_S}; // Boxing failure.
		end else if (is_s) begin
			case (op_ftype)
				`FT_MIN: nxt_res = {BOX, s_min_res};
				`FT_MAX: nxt_res = {BOX, s_max_res};
				`FT_SGNJ: nxt_res = {BOX, s_sgnj_res};
				`FT_SGNJN: nxt_res = {BOX, s_sgnjn_res};
				`FT_SGNJX: nxt_res = {BOX, s_sgnjx_res};
				`FT_EQ: nxt_res = fp_misc_pkg::freg_t'(s_eq & ~s_unordered);
				`FT_LT: nxt_res = fp_misc_pkg::freg_t'(s_lt & ~s_unordered);
				`FT_LE: nxt_res = fp_misc_pkg::freg_t'((s_lt | s_eq) & ~s_unordered);
				`FT_CLASS: nxt_res = fp_misc_pkg::freg_t'(s_class_mask);
				`FT_MV_TO_F: nxt_res = {BOX, op_a[`FLEN_S-1:0]};
				`FT_MV_TO_X: nxt_res = {{`FLEN_S{op_a[`FLEN_S-1]}}, op_a[`FLEN_S-1:0]};
				default: nxt_res = '0;
			endcase
		end else if (is_d) begin
			case (op_ftype)
				`FT_MIN: nxt_res = d_min_res;
				`FT_MAX: nxt_res = d_max_res;
				`FT_SGNJ: nxt_res = d_sgnj_res;
				`FT_SGNJN: nxt_res = d_sgnjn_res;
				`FT_SGNJX: nxt_res = d_sgnjx_res;
				`FT_EQ: nxt_res = fp_misc_pkg::freg_t'(d_eq & ~d_unordered);
				`FT_LT: nxt_res = fp_misc_pkg::freg_t'(d_lt & ~d_unordered);
				`FT_LE: nxt_res = fp_misc_pkg::freg_t'((d_lt | d_eq) & ~d_unordered);
				`FT_CLASS: nxt_res = fp_misc_pkg::freg_t'(d_class_mask);
				`FT_MV_TO_F, `FT_MV_TO_X: nxt_res = op_a; // Raw bits both ways.
				default: nxt_res = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			fflags_valid <= 1'b0;
			exception_flags <= '0;
		end else begin
			out_valid <= op_valid;
			fflags_valid <= op_valid & nxt_fv;
			exception_flags <= op_valid ? nxt_flags : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (op_valid) begin
			farith_res <= nxt_res;
		end
	end

	a_flags_qual: assert property (@(posedge clk) disable iff (reset)
		!fflags_valid |-> exception_flags == '0)
		else $error("fp_result_select: flags set while fflags_valid is low");

endmodule

`default_nettype wire

/* logic/fp_misc_unit.sv */
`default_nettype none
// ====================
// Two-stage FP misc unit: compares, min/max, sign injection, fclass, moves.
// ====================
`include "fp_misc_config.svh"

module fp_misc_unit (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire fp_misc_pkg::fmt_t fmt,
	input wire fp_misc_pkg::ftype_t ftype,
	input wire fp_misc_pkg::freg_t frs1,
	input wire fp_misc_pkg::freg_t frs2,
	output logic out_valid,
	output fp_misc_pkg::freg_t farith_res,
	output fp_misc_pkg::fflags_t exception_flags,
	output logic fflags_valid
);

	logic op_valid, op_a_boxed, op_b_boxed;
	fp_misc_pkg::fmt_t op_fmt;
	fp_misc_pkg::ftype_t op_ftype;
	fp_misc_pkg::freg_t op_a, op_b;

	// ====================
	// Per-format compare results
	logic s_lt, s_eq, s_unordered, s_cmp_invalid, s_minmax_invalid;
	fp_misc_pkg::fp32_t s_min_res, s_max_res, s_sgnj_res, s_sgnjn_res, s_sgnjx_res;
	fp_misc_pkg::fclass_t s_class_mask;
	logic d_lt, d_eq, d_unordered, d_cmp_invalid, d_minmax_invalid;
	fp_misc_pkg::fp64_t d_min_res, d_max_res, d_sgnj_res, d_sgnjn_res, d_sgnjx_res;
	fp_misc_pkg::fclass_t d_class_mask;

	fp_operand_stage u_operand (.*);

	fp_compare_unit #(.float_t(fp_misc_pkg::fp32_t)) u_cmp_s (
		.a(op_a[`FLEN_S-1:0]), .b(op_b[`FLEN_S-1:0]), // Low word only.
		.lt(s_lt), .eq(s_eq), .unordered(s_unordered), .cmp_invalid(s_cmp_invalid),
		.min_res(s_min_res), .max_res(s_max_res), .minmax_invalid(s_minmax_invalid),
		.sgnj_res(s_sgnj_res), .sgnjn_res(s_sgnjn_res), .sgnjx_res(s_sgnjx_res),
		.class_mask(s_class_mask)
	);

	fp_compare_unit #(.float_t(fp_misc_pkg::fp64_t)) u_cmp_d (
		.a(op_a), .b(op_b),
		.lt(d_lt), .eq(d_eq), .unordered(d_unordered), .cmp_invalid(d_cmp_invalid),
		.min_res(d_min_res), .max_res(d_max_res), .minmax_invalid(d_minmax_invalid),
		.sgnj_res(d_sgnj_res), .sgnjn_res(d_sgnjn_res), .sgnjx_res(d_sgnjx_res),
		.class_mask(d_class_mask)
	);

	fp_result_select u_result (.*);

endmodule

`default_nettype wire

/* sim/fp_misc_tb.sv */
`default_nettype none
// ====================
// Testbench for the FP misc unit. Streams the golden vectors back to back
// and checks each result, its flags and its two-cycle latency.
// ====================

module fp_misc_tb;

	localparam int MAX_VEC = 64;
	localparam int RESET_CYCLES = 5;
	localparam int VEC_W = 216; // fmt, ftype, frs1, frs2, result, flags, fflags_valid.

	logic clk;
	logic reset;
	logic in_valid;
	fp_misc_pkg::fmt_t fmt;
	fp_misc_pkg::ftype_t ftype;
	fp_misc_pkg::freg_t frs1;
	fp_misc_pkg::freg_t frs2;
	logic out_valid;
	fp_misc_pkg::freg_t farith_res;
	fp_misc_pkg::fflags_t exception_flags;
	logic fflags_valid;

	logic [VEC_W-1:0] vectors [MAX_VEC];
	int drive_cycle [MAX_VEC];
	int num_vec = 0;
	int num_sent = 0;
	int num_checked = 0;
	int errors = 0;
	int cycles = 0;
	int timeout_limit = 1000;

	fp_misc_unit UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ====================
	// Cycle count and timeout
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > timeout_limit) begin
			$display("Timeout after %0d cycles, %0d results never arrived.",
				cycles, num_sent - num_checked);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic check_result(input int idx);
		logic [VEC_W-1:0] v;
		fp_misc_pkg::freg_t exp_res;
		fp_misc_pkg::fflags_t exp_flags;
		logic exp_fv;
		v = vectors[idx];
		exp_res = v[75:12];
		exp_flags = v[8:4];
		exp_fv = v[0];
		if (cycles != drive_cycle[idx] + 2) begin
			$display("Error at %0t: vector %0d latency %0d cycles, expected 2",
				$time, idx, cycles - drive_cycle[idx]);
			errors = errors + 1;
		end
		if (farith_res !== exp_res) begin
			$display("Error at %0t: vector %0d farith_res %h, expected %h",
				$time, idx, farith_res, exp_res);
			errors = errors + 1;
		end
		if (exception_flags !== exp_flags) begin
			$display("Error at %0t: vector %0d exception_flags %b, expected %b",
				$time, idx, exception_flags, exp_flags);
			errors = errors + 1;
		end
		if (fflags_valid !== exp_fv) begin
			$display("Error at %0t: vector %0d fflags_valid %b, expected %b",
				$time, idx, fflags_valid, exp_fv);
			errors = errors + 1;
		end
	endtask

	// Outputs are sampled mid-cycle, away from the driving edge.
	always @(negedge clk) begin
		if (reset) begin
			if (cycles > 0 && (out_valid !== 1'b0 || fflags_valid !== 1'b0)) begin
				$display("Error at %0t: out_valid or fflags_valid high in reset", $time);
				errors = errors + 1;
			end
		end else if (out_valid) begin
			if (num_checked >= num_sent) begin
				$display("A result came out at %0t with no input waiting for it.", $time);
				errors = errors + 1;
			end else begin
				check_result(num_checked);
				num_checked = num_checked + 1;
			end
		end
	end

	// ====================
	// Stimulus
	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		fmt = '0;
		ftype = '0;
		frs1 = '0;
		frs2 = '0;
		for (int i = 0; i < MAX_VEC; i++) begin
			vectors[i] = '1; // Top nibble F marks an unused entry.
		end
		$readmemh("sim/fp_misc_golden.hex", vectors);
		while (num_vec < MAX_VEC && vectors[num_vec][VEC_W-1 -: 4] != 4'hF) begin
			num_vec = num_vec + 1;
		end
		if (num_vec == 0) begin
			$display("No test vectors were loaded from the golden file.");
			errors = errors + 1;
		end
		timeout_limit = RESET_CYCLES + num_vec + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0;
		for (int i = 0; i < num_vec; i++) begin
			in_valid = 1'b1;
			fmt = vectors[i][213:212];
			ftype = vectors[i][208:204];
			frs1 = vectors[i][203:140];
			frs2 = vectors[i][139:76];
			drive_cycle[i] = cycles;
			num_sent = i + 1;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
		while (num_checked < num_sent) @(posedge clk);
		repeat (3) @(posedge clk); // Catch any stray out_valid.
		$display("Checked %0d of %0d vectors, %0d errors", num_checked, num_vec, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* fp_misc.f */
+incdir+include
logic/fp_misc_pkg.sv
logic/fp_operand_stage.sv
logic/fp_compare_unit.sv
logic/fp_result_select.sv
logic/fp_misc_unit.sv
sim/fp_misc_tb.sv

/* Makefile */
# Verilator lint, simulation and clean targets for the FP misc unit.
TOP = fp_misc_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f fp_misc.f --top-module fp_misc_unit

sim:
	verilator --binary --timing -f fp_misc.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* sim/fp_misc_golden.hex */
// fmt _ ftype _ frs1 _ frs2 _ expected result _ expected flags (NV = 10) _ expected fflags_valid
// fmt 0 single, 1 double; ftype 03 min, 04 max, 11-13 sgnj/n/x, 14 eq, 15 lt, 16 le, 17 class, 18/19 mv
0_14_FFFFFFFF3F800000_FFFFFFFF3F800000_0000000000000001_00_1
0_15_FFFFFFFF3F800000_FFFFFFFF40000000_0000000000000001_00_1
0_16_FFFFFFFFC0000000_FFFFFFFFBF800000_0000000000000001_00_1
0_14_FFFFFFFF00000000_FFFFFFFF80000000_0000000000000001_00_1
0_14_FFFFFFFF7FC00000_FFFFFFFF3F800000_0000000000000000_00_1
0_14_FFFFFFFF7F800001_FFFFFFFF3F800000_0000000000000000_10_1
1_16_3FF0000000000000_3FF0000000000000_0000000000000001_00_1
1_16_7FF8000000000000_3FF0000000000000_0000000000000000_10_1
0_03_FFFFFFFF00000000_FFFFFFFF80000000_FFFFFFFF80000000_00_1
0_04_FFFFFFFF80000000_FFFFFFFF00000000_FFFFFFFF00000000_00_1
1_04_3FF0000000000000_7FF0000000000001_3FF0000000000000_10_1
1_03_7FF8000000000000_7FF8000000000000_7FF8000000000000_00_1
0_04_FFFFFFFF7F800001_FFFFFFFF7FC00000_FFFFFFFF7FC00000_10_1
0_11_FFFFFFFF3F800000_FFFFFFFFC0000000_FFFFFFFFBF800000_00_0
0_12_FFFFFFFF3F800000_FFFFFFFFC0000000_FFFFFFFF3F800000_00_0
1_13_BFF0000000000000_C000000000000000_3FF0000000000000_00_0
0_18_0000000012345678_0000000000000000_FFFFFFFF12345678_00_0
0_19_0123456789ABCDEF_0000000000000000_FFFFFFFF89ABCDEF_00_0
1_18_0123456789ABCDEF_0000000000000000_0123456789ABCDEF_00_0
0_17_FFFFFFFFFF800000_0000000000000000_0000000000000001_00_0
0_17_FFFFFFFFBF800000_0000000000000000_0000000000000002_00_0
0_17_FFFFFFFF80000001_0000000000000000_0000000000000004_00_0
0_17_FFFFFFFF80000000_0000000000000000_0000000000000008_00_0
0_17_FFFFFFFF00000000_0000000000000000_0000000000000010_00_0
0_17_FFFFFFFF00000001_0000000000000000_0000000000000020_00_0
1_17_3FF0000000000000_0000000000000000_0000000000000040_00_0
1_17_7FF0000000000000_0000000000000000_0000000000000080_00_0
1_17_7FF0000000000001_0000000000000000_0000000000000100_00_0
1_17_7FF8000000000000_0000000000000000_0000000000000200_00_0
0_11_FFFFFFFF3F800000_123456783F800000_000000007FC00000_10_1
0_00_FFFFFFFF3F800000_FFFFFFFF3F800000_0000000000000000_00_0
2_14_FFFFFFFF3F800000_FFFFFFFF3F800000_0000000000000000_00_0
